// File: project.f
logic/isaPkg.sv
logic/pipePkg.sv
logic/stageReg.sv
logic/regFile.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memoryStage.sv
logic/cpuTop.sv
tests/cpuTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

logFile=sim.log

if ! verilator --binary --timing --assert -f project.f --top-module cpuTb -o cpuSim; then
	echo "Verilator build failed"
	exit 1
fi

obj_dir/cpuSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

if [ "$simStatus" -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -qx "Test OK" "$logFile"; then
	exit 0
else
	echo "Pass line not found in $logFile"
	exit 1
fi

// File: tests/cpuTb.sv
// Pipelined core testbench
`default_nettype none

module cpuTb import isaPkg::*, pipePkg::*; ();

	localparam int numProgs = 4;
	localparam int maxLen = 32;
	localparam int maxWb = 12;
	localparam int abortProg = 0;

	logic clk = 1'b0;
	logic rstN;
	logic run;
	progWriteT progWrite;
	wbPortT wb;
	logic halted;

	// Program table and expected writeback sequence per entry
	logic [dataWidth-1:0] progMem [numProgs][maxLen];
	int progLen [numProgs];
	logic [3:0] expReg [numProgs][maxWb];
	logic [dataWidth-1:0] expVal [numProgs][maxWb];
	int expCount [numProgs];

	int cycles = 0;
	int cycleLimit = 0;

	cpuTop #(.imemWords(256), .dmemWords(256)) dut (
		.clk(clk),
		.rstN(rstN),
		.run(run),
		.progWrite(progWrite),
		.wb(wb),
		.halted(halted)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= cycleLimit) begin
			$display("Timeout after %0d cycles, the core never reached its halt", cycles);
			$display("Test FAILED");
			$fatal(1);
		end
	end

	task automatic expectEqual(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Fail at time %0t: %s is %0h, expected %0h", $time, name, actual, expected);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	function automatic logic [15:0] encR(input opcodeE op, input logic [3:0] rd,
		input logic [3:0] rs, input logic [3:0] rt);
		return {op, rd, rs, rt};
	endfunction

	function automatic logic [15:0] encI(input opcodeE op, input logic [3:0] rd,
		input logic [7:0] imm);
		return {op, rd, imm};
	endfunction

	task automatic addInstr(input int p, input logic [15:0] word);
		progMem[p][progLen[p]] = word;
		progLen[p] = progLen[p] + 1;
	endtask

	// Instruction followed by gap NOPs
	task automatic addStep(input int p, input int gap, input logic [15:0] word);
		addInstr(p, word);
		for (int i = 0; i < gap; i++) begin
			addInstr(p, 16'h0000);
		end
	endtask

	task automatic addWb(input int p, input logic [3:0] regAddr, input logic [15:0] value);
		expReg[p][expCount[p]] = regAddr;
		expVal[p][expCount[p]] = value;
		expCount[p] = expCount[p] + 1;
	endtask

	task automatic buildTables();
		for (int p = 0; p < numProgs; p++) begin
			progLen[p] = 0;
			expCount[p] = 0;
		end
		// Entry 0 back to back, entry 1 the same chain spaced by two NOPs
		for (int p = 0; p < 2; p++) begin
			addStep(p, 2 * p, encI(opLdi, 4'd1, 8'h05));
			addWb(p, 4'd1, 16'h0005);
			addStep(p, 2 * p, encI(opLdi, 4'd2, 8'hfd));
			addWb(p, 4'd2, 16'hfffd);
			addStep(p, 2 * p, encR(opAdd, 4'd3, 4'd1, 4'd2));
			addWb(p, 4'd3, 16'h0002);
			addStep(p, 2 * p, encR(opSub, 4'd4, 4'd1, 4'd2));
			addWb(p, 4'd4, 16'h0008);
			addStep(p, 2 * p, encR(opAnd, 4'd5, 4'd1, 4'd2));
			addWb(p, 4'd5, 16'h0005);
			addStep(p, 2 * p, encR(opOr, 4'd6, 4'd1, 4'd2));
			addWb(p, 4'd6, 16'hfffd);
			addStep(p, 2 * p, encR(opXor, 4'd7, 4'd1, 4'd2));
			addWb(p, 4'd7, 16'hfff8);
			// The pulse carries the sum, but r0 keeps reading zero
			addStep(p, 2 * p, encR(opAdd, 4'd0, 4'd1, 4'd1));
			addWb(p, 4'd0, 16'h000a);
			addStep(p, 2 * p, encR(opAdd, 4'd8, 4'd0, 4'd1));
			addWb(p, 4'd8, 16'h0005);
			addStep(p, 2 * p, encR(opAdd, 4'd9, 4'd3, 4'd3));
			addWb(p, 4'd9, 16'h0004);
			addInstr(p, {opHalt, 12'h000});
		end
		// Every taken branch skips two shadow LDIs
		addInstr(2, encI(opLdi, 4'd1, 8'h01));
		addInstr(2, encI(opLdi, 4'd2, 8'h01));
		addInstr(2, encR(opSub, 4'd3, 4'd1, 4'd2));
		addInstr(2, encI(opBr, condZero, 8'd2));
		addInstr(2, encI(opLdi, 4'd4, 8'h11));
		addInstr(2, encI(opLdi, 4'd5, 8'h22));
		addInstr(2, encI(opBr, condNotZero, 8'd2));
		addInstr(2, encI(opLdi, 4'd6, 8'h33));
		addInstr(2, encR(opSub, 4'd7, 4'd1, 4'd6));
		addInstr(2, encI(opBr, condNeg, 8'd2));
		addInstr(2, encI(opLdi, 4'd8, 8'h44));
		addInstr(2, encI(opLdi, 4'd8, 8'h55));
		addInstr(2, encI(opBr, condCarry, 8'd2));
		addInstr(2, encI(opLdi, 4'd9, 8'h66));
		addInstr(2, encI(opLdi, 4'd9, 8'h77));
		addInstr(2, encI(opBr, condZero, 8'd2));
		addInstr(2, encI(opLdi, 4'd10, 8'h12));
		addInstr(2, encR(opAdd, 4'd11, 4'd1, 4'd2));
		addInstr(2, encI(opBr, condNeg, 8'd2));
		addInstr(2, encI(opBr, condCarry, 8'd2));
		addInstr(2, encI(opBr, condNotZero, 8'd2));
		addInstr(2, encI(opLdi, 4'd12, 8'h88));
		addInstr(2, encI(opLdi, 4'd12, 8'h99));
		addInstr(2, encI(opBr, condAlways, 8'd2));
		addInstr(2, encI(opLdi, 4'd14, 8'haa));
		addInstr(2, encI(opLdi, 4'd14, 8'hbb));
		addInstr(2, encI(opLdi, 4'd13, 8'hff));
		addInstr(2, {opHalt, 12'h000});
		addWb(2, 4'd1, 16'h0001);
		addWb(2, 4'd2, 16'h0001);
		addWb(2, 4'd3, 16'h0000);
		addWb(2, 4'd6, 16'h0033);
		addWb(2, 4'd7, 16'hffce);
		addWb(2, 4'd10, 16'h0012);
		addWb(2, 4'd11, 16'h0002);
		addWb(2, 4'd13, 16'hffff);
		// Store then load from the same address
		addInstr(3, encI(opLdi, 4'd1, 8'h20));
		addInstr(3, encI(opLdi, 4'd2, 8'ha5));
		addInstr(3, encR(opSt, 4'd2, 4'd1, 4'd0));
		addInstr(3, encR(opLd, 4'd3, 4'd1, 4'd0));
		addInstr(3, encR(opAdd, 4'd4, 4'd3, 4'd1));
		addInstr(3, {opHalt, 12'h000});
		addWb(3, 4'd1, 16'h0020);
		addWb(3, 4'd2, 16'hffa5);
		addWb(3, 4'd3, 16'hffa5);
		addWb(3, 4'd4, 16'hffc5);
	endtask

	task automatic applyReset();
		@(negedge clk);
		rstN = 1'b0;
		run = 1'b0;
		progWrite = '0;
		repeat (10) @(negedge clk);
		rstN = 1'b1;
	endtask

	task automatic loadProgram(input int p);
		for (int i = 0; i < progLen[p]; i++) begin
			progWrite.write = 1'b1;
			progWrite.addr = 8'(i);
			progWrite.instr = progMem[p][i];
			@(negedge clk);
		end
		progWrite = '0;
	endtask

	// Record retirements until halted, then compare with the table
	task automatic runAndCheck(input int p);
		logic [3:0] gotReg [$];
		logic [dataWidth-1:0] gotVal [$];
		logic done;
		done = 1'b0;
		run = 1'b1;
		while (!done) begin
			@(negedge clk);
			if (wb.valid) begin
				gotReg.push_back(wb.regAddr);
				gotVal.push_back(wb.data);
			end
			done = halted;
		end
		expectEqual($sformatf("writeback count of program %0d", p),
			32'(gotReg.size()), 32'(expCount[p]));
		for (int i = 0; i < expCount[p]; i++) begin
			expectEqual($sformatf("wb.regAddr #%0d of program %0d", i, p),
				32'(gotReg[i]), 32'(expReg[p][i]));
			expectEqual($sformatf("wb.data #%0d of program %0d", i, p),
				32'(gotVal[i]), 32'(expVal[p][i]));
		end
	endtask

	task automatic abortAndRerun(input int p, input int retireCount);
		int seen;
		seen = 0;
		applyReset();
		loadProgram(p);
		run = 1'b1;
		while (seen < retireCount) begin
			@(negedge clk);
			if (wb.valid) begin
				seen++;
			end
		end
		expectEqual("halted", 32'(halted), 32'(0));
		rstN = 1'b0;
		run = 1'b0;
		@(negedge clk);
		expectEqual("wb.valid", 32'(wb.valid), 32'(0));
		repeat (9) @(negedge clk);
		expectEqual("halted", 32'(halted), 32'(0));
		rstN = 1'b1;
		// Program memory survives reset
		runAndCheck(p);
	endtask

	initial begin
		rstN = 1'b0;
		run = 1'b0;
		progWrite = '0;
		buildTables();
		for (int p = 0; p < numProgs; p++) begin
			cycleLimit = cycleLimit + 4 * progLen[p] + 20;
		end
		cycleLimit = cycleLimit + 4 * progLen[abortProg] + 20;
		for (int p = 0; p < numProgs; p++) begin
			applyReset();
			loadProgram(p);
			runAndCheck(p);
		end
		// Reset lands one writeback short of the end, just ahead of the HALT
		abortAndRerun(abortProg, expCount[abortProg] - 1);
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: logic/cpuTop.sv
// Five-stage pipelined core
`default_nettype none

module cpuTop import isaPkg::*, pipePkg::*; #(
	parameter int imemWords = 256,
	parameter int dmemWords = 256
) (
	input logic clk,
	input logic rstN,
	input logic run,
	input progWriteT progWrite,
	output wbPortT wb,
	output logic halted
);

	ifIdT fetchOut, ifIdQ;
	idExT decodeOut, idExQ;
	exMemT executeOut, exMemQ;
	memWbT memoryOut, memWbQ;

	logic stall;
	logic halting;
	logic branchTaken;
	logic [dataWidth-1:0] branchTarget;

	fetchStage #(.imemWords(imemWords)) fetch (
		.clk(clk),
		.rstN(rstN),
		.run(run),
		.halting(halting),
		.stall(stall),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.progWrite(progWrite),
		.fetched(fetchOut)
	);

	stageReg #(.payloadT(ifIdT)) ifId (
		.clk(clk), .rstN(rstN), .hold(stall), .flush(branchTaken),
		.d(fetchOut), .q(ifIdQ)
	);

	decodeStage decode (
		.clk(clk),
		.rstN(rstN),
		.fromIfId(ifIdQ),
		.exDest(idExQ),
		.memDest(exMemQ),
		.fromMemWb(memWbQ),
		.toIdEx(decodeOut),
		.stall(stall),
		.halting(halting)
	);

	// Stalled instruction leaves a bubble behind it
	stageReg #(.payloadT(idExT)) idEx (
		.clk(clk), .rstN(rstN), .hold(1'b0), .flush(stall || branchTaken),
		.d(decodeOut), .q(idExQ)
	);

	executeStage execute (
		.clk(clk),
		.rstN(rstN),
		.fromIdEx(idExQ),
		.toExMem(executeOut),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget)
	);

	stageReg #(.payloadT(exMemT)) exMem (
		.clk(clk), .rstN(rstN), .hold(1'b0), .flush(1'b0),
		.d(executeOut), .q(exMemQ)
	);

	memoryStage #(.dmemWords(dmemWords)) memory (
		.clk(clk),
		.rstN(rstN),
		.fromExMem(exMemQ),
		.toMemWb(memoryOut),
		.halted(halted)
	);

	stageReg #(.payloadT(memWbT)) memWb (
		.clk(clk), .rstN(rstN), .hold(1'b0), .flush(1'b0),
		.d(memoryOut), .q(memWbQ)
	);

	assign wb.valid = memWbQ.valid && memWbQ.regWrite;
	assign wb.regAddr = memWbQ.rd;
	assign wb.data = memWbQ.result;

endmodule

`default_nettype wire

// File: logic/memoryStage.sv
// Data memory access
`default_nettype none

module memoryStage import isaPkg::*, pipePkg::*; #(
	parameter int dmemWords = 256
) (
	input logic clk,
	input logic rstN,
	input exMemT fromExMem,
	output memWbT toMemWb,
	output logic halted
);

	localparam int addrBits = $clog2(dmemWords);

	logic [dataWidth-1:0] dmem [dmemWords];
	logic [addrBits-1:0] addr;

	assign addr = fromExMem.result[addrBits-1:0];

	always_ff @(posedge clk) begin
		if (fromExMem.valid && fromExMem.memWrite) begin
			dmem[addr] <= fromExMem.storeData;
		end
	end

	// Sticky until reset
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			halted <= 1'b0;
		end else if (fromExMem.valid && fromExMem.halt) begin
			halted <= 1'b1;
		end
	end

	assign toMemWb.valid = fromExMem.valid;
	assign toMemWb.rd = fromExMem.rd;
	assign toMemWb.result = fromExMem.memRead ? dmem[addr] : fromExMem.result;
	assign toMemWb.regWrite = fromExMem.regWrite;
	assign toMemWb.halt = fromExMem.halt;

endmodule

`default_nettype wire

// File: logic/executeStage.sv
// ALU, status flags and branch resolution
`default_nettype none

module executeStage import isaPkg::*, pipePkg::*; (
	input logic clk,
	input logic rstN,
	input idExT fromIdEx,
	output exMemT toExMem,
	output logic branchTaken,
	output logic [dataWidth-1:0] branchTarget
);

	flagsT flags;
	flagsT newFlags;
	logic [dataWidth:0] wide;
	logic [dataWidth-1:0] result;
	logic isAlu;
	logic condMet;

	assign isAlu = fromIdEx.op inside {opAdd, opSub, opAnd, opOr, opXor};

	always_comb begin
		wide = '0;
		case (fromIdEx.op)
			opAdd: wide = {1'b0, fromIdEx.opA} + {1'b0, fromIdEx.opB};
			opSub: wide = {1'b0, fromIdEx.opA} - {1'b0, fromIdEx.opB};
			opAnd: wide = {1'b0, fromIdEx.opA & fromIdEx.opB};
			opOr: wide = {1'b0, fromIdEx.opA | fromIdEx.opB};
			opXor: wide = {1'b0, fromIdEx.opA ^ fromIdEx.opB};
			opLdi: wide = {1'b0, fromIdEx.imm};
			default: wide = {1'b0, fromIdEx.opA};
		endcase
	end

	// Top bit is carry for ADD, borrow for SUB
	assign result = wide[dataWidth-1:0];
	assign newFlags.zero = result == '0;
	assign newFlags.negative = result[dataWidth-1];
	assign newFlags.carry = wide[dataWidth];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			flags <= '0;
		end else if (fromIdEx.valid && isAlu) begin
			flags <= newFlags;
		end
	end

	always_comb begin
		case (fromIdEx.cond)
			condAlways: condMet = 1'b1;
			condZero: condMet = flags.zero;
			condNotZero: condMet = !flags.zero;
			condNeg: condMet = flags.negative;
			condCarry: condMet = flags.carry;
			default: condMet = 1'b0;
		endcase
	end

	assign branchTaken = fromIdEx.valid && fromIdEx.op == opBr && condMet;
	assign branchTarget = fromIdEx.opA + 1'b1 + fromIdEx.imm;

	assign toExMem.valid = fromIdEx.valid;
	assign toExMem.rd = fromIdEx.rd;
	assign toExMem.result = result;
	assign toExMem.storeData = fromIdEx.opB;
	assign toExMem.regWrite = fromIdEx.regWrite;
	assign toExMem.memRead = fromIdEx.memRead;
	assign toExMem.memWrite = fromIdEx.memWrite;
	assign toExMem.halt = fromIdEx.halt;

	// Only a valid BR redirects, and the slot behind it is squashed
	aBranchSource: assert property (
		@(posedge clk) disable iff (!rstN)
		branchTaken |-> (fromIdEx.valid && fromIdEx.op == opBr) ##1 !fromIdEx.valid
	);

endmodule

`default_nettype wire

// File: logic/decodeStage.sv
// Instruction decode and hazard detection
`default_nettype none

module decodeStage import isaPkg::*, pipePkg::*; (
	input logic clk,
	input logic rstN,
	input ifIdT fromIfId,
	input idExT exDest,
	input exMemT memDest,
	input memWbT fromMemWb,
	output idExT toIdEx,
	output logic stall,
	output logic halting
);

	opcodeE op;
	logic [regAddrWidth-1:0] rd;
	logic [regAddrWidth-1:0] rs;
	logic [regAddrWidth-1:0] rt;
	logic [regAddrWidth-1:0] readAddrB;
	logic [dataWidth-1:0] readDataA;
	logic [dataWidth-1:0] readDataB;
	logic isAlu;
	logic useRs;
	logic useB;

	// Source is written by an older instruction still in flight
	function automatic logic pending(input logic [regAddrWidth-1:0] src);
		logic inEx;
		logic inMem;
		inEx = exDest.valid && exDest.regWrite && exDest.rd == src;
		inMem = memDest.valid && memDest.regWrite && memDest.rd == src;
		return src != '0 && (inEx || inMem);
	endfunction

	assign op = opcodeE'(fromIfId.instr[opcodeLsb +: 4]);
	assign rd = fromIfId.instr[rdLsb +: regAddrWidth];
	assign rs = fromIfId.instr[rsLsb +: regAddrWidth];
	assign rt = fromIfId.instr[rtLsb +: regAddrWidth];

	assign isAlu = op inside {opAdd, opSub, opAnd, opOr, opXor};
	assign useRs = isAlu || op == opLd || op == opSt;
	assign useB = isAlu || op == opSt;

	// ST reads its data from rd
	assign readAddrB = (op == opSt) ? rd : rt;

	regFile regs (
		.clk(clk),
		.rstN(rstN),
		.writeEnable(fromMemWb.valid && fromMemWb.regWrite),
		.writeAddr(fromMemWb.rd),
		.writeData(fromMemWb.result),
		.readAddrA(rs),
		.readAddrB(readAddrB),
		.readDataA(readDataA),
		.readDataB(readDataB)
	);

	assign stall = fromIfId.valid && ((useRs && pending(rs)) || (useB && pending(readAddrB)));
	assign halting = fromIfId.valid && op == opHalt;

	assign toIdEx.valid = fromIfId.valid;
	assign toIdEx.op = op;
	assign toIdEx.cond = condE'(rd);
	assign toIdEx.rd = rd;
	assign toIdEx.opA = (op == opBr) ? fromIfId.pc : readDataA;
	assign toIdEx.opB = readDataB;
	assign toIdEx.imm = {{(dataWidth - immWidth){fromIfId.instr[immWidth-1]}},
		fromIfId.instr[immWidth-1:0]};
	assign toIdEx.regWrite = isAlu || op == opLdi || op == opLd;
	assign toIdEx.memRead = op == opLd;
	assign toIdEx.memWrite = op == opSt;
	assign toIdEx.halt = op == opHalt;

endmodule

`default_nettype wire

// File: logic/fetchStage.sv
// Instruction fetch
`default_nettype none

module fetchStage import isaPkg::*, pipePkg::*; #(
	parameter int imemWords = 256
) (
	input logic clk,
	input logic rstN,
	input logic run,
	input logic halting,
	input logic stall,
	input logic branchTaken,
	input logic [dataWidth-1:0] branchTarget,
	input progWriteT progWrite,
	output ifIdT fetched
);

	localparam int addrBits = $clog2(imemWords);

	logic [dataWidth-1:0] imem [imemWords];
	logic [dataWidth-1:0] pc;
	logic stopped;
	logic advance;

	assign advance = run && !halting && !stopped && !stall;

	always_ff @(posedge clk) begin
		if (progWrite.write) begin
			imem[progWrite.addr[addrBits-1:0]] <= progWrite.instr;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
			stopped <= 1'b0;
		end else begin
			if (branchTaken) begin
				pc <= branchTarget;
			end else if (advance) begin
				pc <= pc + 1'b1;
			end
			// A HALT flushed by an older branch does not stop fetch
			if (halting && !branchTaken) begin
				stopped <= 1'b1;
			end
		end
	end

	assign fetched.valid = advance;
	assign fetched.pc = pc;
	assign fetched.instr = imem[pc[addrBits-1:0]];

	aNoWriteWhileRunning: assert property (
		@(posedge clk) disable iff (!rstN)
		run |-> !progWrite.write
	);

endmodule

`default_nettype wire

// File: logic/regFile.sv
// Register file
`default_nettype none

module regFile import isaPkg::*; (
	input logic clk,
	input logic rstN,
	input logic writeEnable,
	input logic [3:0] writeAddr,
	input logic [dataWidth-1:0] writeData,
	input logic [3:0] readAddrA,
	input logic [3:0] readAddrB,
	output logic [dataWidth-1:0] readDataA,
	output logic [dataWidth-1:0] readDataB
);

	logic [dataWidth-1:0] regs [16];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable && writeAddr != 4'd0) begin
			regs[writeAddr] <= writeData;
		end
	end

	// Write-through covers the writeback stage
	assign readDataA = (readAddrA == 4'd0) ? '0 :
		(writeEnable && writeAddr == readAddrA) ? writeData : regs[readAddrA];
	assign readDataB = (readAddrB == 4'd0) ? '0 :
		(writeEnable && writeAddr == readAddrB) ? writeData : regs[readAddrB];

	aZeroReg: assert property (
		@(posedge clk) disable iff (!rstN)
		(readAddrA == 4'd0 |-> readDataA == '0) and (readAddrB == 4'd0 |-> readDataB == '0)
	);

endmodule

`default_nettype wire

// File: logic/stageReg.sv
// Pipeline buffer
`default_nettype none

module stageReg #(
	parameter type payloadT = logic
) (
	input logic clk,
	input logic rstN,
	input logic hold,
	input logic flush,
	input payloadT d,
	output payloadT q
);

	// All-zero payload is a bubble since valid is low
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			q <= '0;
		end else if (flush) begin
			q <= '0;
		end else if (!hold) begin
			q <= d;
		end
	end

	aFlushOverHold: assert property (
		@(posedge clk) disable iff (!rstN)
		flush && hold |=> q == '0
	);

endmodule

`default_nettype wire

// File: logic/pipePkg.sv
// Pipeline buffer payloads
`default_nettype none

package pipePkg;

	import isaPkg::*;

	typedef struct packed {
		logic write;
		logic [7:0] addr;
		logic [dataWidth-1:0] instr;
	} progWriteT;

	typedef struct packed {
		logic valid;
		logic [dataWidth-1:0] pc;
		logic [dataWidth-1:0] instr;
	} ifIdT;

	// opA carries the PC for BR
	typedef struct packed {
		logic valid;
		opcodeE op;
		condE cond;
		logic [regAddrWidth-1:0] rd;
		logic [dataWidth-1:0] opA;
		logic [dataWidth-1:0] opB;
		logic [dataWidth-1:0] imm;
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic halt;
	} idExT;

	typedef struct packed {
		logic valid;
		logic [regAddrWidth-1:0] rd;
		logic [dataWidth-1:0] result;
		logic [dataWidth-1:0] storeData;
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic halt;
	} exMemT;

	typedef struct packed {
		logic valid;
		logic [regAddrWidth-1:0] rd;
		logic [dataWidth-1:0] result;
		logic regWrite;
		logic halt;
	} memWbT;

	typedef struct packed {
		logic valid;
		logic [regAddrWidth-1:0] regAddr;
		logic [dataWidth-1:0] data;
	} wbPortT;

endpackage

`default_nettype wire

// File: logic/isaPkg.sv
// Instruction set definitions
`default_nettype none

package isaPkg;

	localparam int dataWidth = 16;
	localparam int regAddrWidth = 4;

	// Instruction field positions
	localparam int opcodeLsb = 12;
	localparam int rdLsb = 8;
	localparam int rsLsb = 4;
	localparam int rtLsb = 0;
	localparam int immWidth = 8;

	typedef enum logic [3:0] {
		opNop = 4'h0,
		opAdd = 4'h1,
		opSub = 4'h2,
		opAnd = 4'h3,
		opOr = 4'h4,
		opXor = 4'h5,
		opLdi = 4'h6,
		opLd = 4'h7,
		opSt = 4'h8,
		opBr = 4'h9,
		opHalt = 4'hf
	} opcodeE;

	// Branch condition, carried in the rd field
	typedef enum logic [3:0] {
		condAlways = 4'h0,
		condZero = 4'h1,
		condNotZero = 4'h2,
		condNeg = 4'h3,
		condCarry = 4'h4
	} condE;

	typedef struct packed {
		logic zero;
		logic negative;
		logic carry;
	} flagsT;

endpackage

`default_nettype wire
